// File: filelist.f
+incdir+.
autotest_pkg.sv
ctrl_block_capture.sv
feed_assembler.sv
autotest_fsm.sv
autotest_top.sv
sd_host_model.sv
autotest_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= autotest_tb
RTL_TOP    ?= autotest_top
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --timing
VFLAGS     ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: autotest_tb.sv
// autotest testbench
`timescale 1ns/10ps
`default_nettype none

`include "autotest_config.svh"

module autotest_tb
  import autotest_pkg::*;
();

  localparam int NUM_CB     = 4;
  localparam int CARD_BYTES = 16 * `AT_BLOCK_BYTES;
  localparam int WAIT_LIMIT = 20000;
  localparam int HALT_WATCH = 2000;

  logic        clk;
  logic        rst;
  logic        spi_busy;
  logic [7:0]  spi_data;
  spi_req_t    spi_req;
  logic [31:0] spi_block_addr;
  logic        uut_busy;
  logic        uut_end;
  logic        uut_err;
  logic [31:0] uut_result;
  logic        uut_rst;
  logic [63:0] uut_input;
  logic [31:0] feed_data;
  logic        feed_strobe;
  logic        stop_feed;
  logic [31:0] error_count;

  logic [7:0]  card [0:CARD_BYTES-1];
  logic [15:0] lfsr_q;
  int          cb_block [NUM_CB];
  int          next_b [NUM_CB];
  int          total_b [NUM_CB];
  logic [31:0] expect_v [NUM_CB];
  logic [31:0] result_v [NUM_CB];
  logic        err_v [NUM_CB];
  int          cur_test;
  int          word_count;
  int          stop_count;
  int          err_total;

  autotest_top i_autotest_top (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy),
    .spi_data_i       (spi_data),
    .spi_req_o        (spi_req),
    .spi_block_addr_o (spi_block_addr),
    .uut_busy_i       (uut_busy),
    .uut_end_i        (uut_end),
    .uut_err_i        (uut_err),
    .uut_result_i     (uut_result),
    .uut_rst_o        (uut_rst),
    .uut_input_o      (uut_input),
    .feed_data_o      (feed_data),
    .feed_strobe_o    (feed_strobe),
    .stop_feed_o      (stop_feed),
    .error_count_o    (error_count)
  );

  sd_host_model #(.MEM_BYTES(CARD_BYTES)) i_sd_host_model (
    .clk          (clk),
    .rst          (rst),
    .req_i        (spi_req),
    .block_addr_i (spi_block_addr),
    .busy_o       (spi_busy),
    .data_o       (spi_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reporting and random bytes
  ////////////////////////////////////////////////////////////
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "testbench stopped");
  endtask

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_rand_byte(output logic [7:0] b);
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      b      = {b[6:0], lfsr_q[0]};
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model of the card layout
  ////////////////////////////////////////////////////////////
  function automatic logic [63:0] ref_uut_input(input int t);
    logic [63:0] v;
    int          base;
    v    = '0;
    base = cb_block[t] * `AT_BLOCK_BYTES;
    for (int i = 7; i >= 0; i--) begin
      v = {v[55:0], card[base + 4 + i]};
    end
    return v;
  endfunction

  // big endian feed words from the block after the control block
  function automatic logic [31:0] ref_feed_word(input int t, input int n);
    int base;
    base = (cb_block[t] + 1) * `AT_BLOCK_BYTES + n * `AT_FEED_BYTES;
    return {card[base], card[base + 1], card[base + 2], card[base + 3]};
  endfunction

  function automatic logic ref_error(input int t);
    return (result_v[t] != expect_v[t]) || err_v[t];
  endfunction

  task automatic put_word(input int addr, input logic [31:0] w, input bit msb_first);
    for (int i = 0; i < 4; i++) begin
      card[addr + i] = msb_first ? w[8*(3-i) +: 8] : w[8*i +: 8];
    end
  endtask

  task automatic build_card();
    int         base;
    logic [7:0] b;
    for (int a = 0; a < CARD_BYTES; a++) begin
      card[a] = a[7:0] ^ {3'b000, a[12:8]};
    end
    for (int t = 0; t < NUM_CB; t++) begin
      base = cb_block[t] * `AT_BLOCK_BYTES;
      // last block carries a broken signature
      put_word(base, (t == NUM_CB - 1) ? (`AT_SIGNATURE ^ 32'h1) : `AT_SIGNATURE, 1'b1);
      for (int i = 0; i < `AT_INPUT_BYTES; i++) begin
        take_rand_byte(b);
        card[base + 4 + i] = b;
      end
      put_word(base + 12, next_b[t], 1'b0);
      put_word(base + 16, total_b[t], 1'b0);
      put_word(base + 20, expect_v[t], 1'b0);
      for (int i = 0; i < total_b[t]; i++) begin
        take_rand_byte(b);
        card[base + `AT_BLOCK_BYTES + i] = b;
      end
    end
    for (int a = 0; a < CARD_BYTES; a++) begin
      i_sd_host_model.mem[a] = card[a];
    end
  endtask

  task automatic wait_req(input logic [3:0] mask, input logic level, input string what);
    int cycles;
    cycles = 0;
    while ((|(spi_req & mask)) != level) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        fail_run($sformatf("timeout waiting for %s", what));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // uut model and feed monitor
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin : uut_model
    int   busy_left;
    int   end_left;
    logic strobe_seen;
    if (rst) begin
      busy_left   = 0;
      end_left    = 0;
      strobe_seen = 1'b0;
      uut_busy    <= 1'b0;
      uut_end     <= 1'b0;
      uut_err     <= 1'b0;
    end else begin
      uut_end <= 1'b0;
      uut_err <= 1'b0;
      // word taken on the rising edge after the strobe
      if (strobe_seen) begin
        busy_left = 3;
        uut_busy  <= 1'b1;
      end else if (busy_left > 0) begin
        busy_left = busy_left - 1;
        if (busy_left == 0) begin
          uut_busy <= 1'b0;
        end
      end
      strobe_seen = feed_strobe;
      if (stop_feed) begin
        end_left = 6;
      end else if (end_left > 0) begin
        end_left = end_left - 1;
        if (end_left == 0) begin
          uut_end    <= 1'b1;
          uut_err    <= err_v[cur_test];
          uut_result <= result_v[cur_test];
        end
      end
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (feed_strobe) begin
        check_equal("stop_feed_o before feed_strobe_o", stop_count, 0);
        check_equal("feed_data_o", feed_data, ref_feed_word(cur_test, word_count));
        word_count = word_count + 1;
      end
      if (stop_feed) begin
        stop_count = stop_count + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    rst        = 1'b1;
    uut_busy   = 1'b0;
    uut_end    = 1'b0;
    uut_err    = 1'b0;
    uut_result = '0;
    lfsr_q     = 16'd57694;
    cur_test   = 0;
    word_count = 0;
    stop_count = 0;
    err_total  = 0;
    cb_block   = '{`AT_START_BLOCK, 8, 12, 14};
    next_b     = '{8, 12, 14, 0};
    total_b    = '{12, 520, 8, 4};
    expect_v   = '{32'h1357_9BDF, 32'h2468_ACE0, 32'hC0FF_EE00, 32'h0};
    // second test mismatches, third flags uut_err
    result_v   = '{32'h1357_9BDF, 32'h2468_ADE0, 32'hC0FF_EE00, 32'h0};
    err_v      = '{1'b0, 1'b0, 1'b1, 1'b0};
    build_card();

    repeat (8) @(negedge clk);
    check_equal("spi_req_o", spi_req, 4'b0000);
    check_equal("feed_strobe_o", feed_strobe, 1'b0);
    check_equal("stop_feed_o", stop_feed, 1'b0);
    check_equal("uut_rst_o", uut_rst, 1'b1);
    check_equal("error_count_o", error_count, 32'd0);
    rst <= 1'b0;

    wait_req(4'hF, 1'b1, "the first SPI request");
    check_equal("spi_req_o", spi_req, 4'b1000);
    check_equal("uut_rst_o", uut_rst, 1'b1);
    check_equal("error_count_o", error_count, 32'd0);

    for (int t = 0; t < NUM_CB; t++) begin
      wait_req(4'b0100, 1'b1, "a control block read");
      // previous test is over once the next read opens
      if (t > 0) begin
        check_equal("feed word count", word_count, total_b[t-1] / `AT_FEED_BYTES);
        check_equal("stop_feed_o pulses", stop_count, 1);
        check_equal("error_count_o", error_count, err_total);
      end
      cur_test   = t;
      word_count = 0;
      stop_count = 0;
      check_equal("spi_block_addr_o", spi_block_addr, cb_block[t]);
      check_equal("uut_rst_o", uut_rst, 1'b1);
      if (t < NUM_CB - 1) begin
        wait_req(4'b0010, 1'b1, "the feed read");
        check_equal("uut_input_o", uut_input, ref_uut_input(t));
        check_equal("spi_block_addr_o", spi_block_addr, cb_block[t] + 1);
        check_equal("uut_rst_o", uut_rst, 1'b0);
        err_total = err_total + int'(ref_error(t));
      end
    end

    // bad signature leaves the sequencer quiet
    wait_req(4'b0100, 1'b0, "the end of the last control block read");
    for (int i = 0; i < HALT_WATCH; i++) begin
      @(negedge clk);
      check_equal("spi_req_o", spi_req, 4'b0000);
      check_equal("feed_strobe_o", feed_strobe, 1'b0);
    end
    check_equal("feed word count", word_count, 0);
    check_equal("stop_feed_o pulses", stop_count, 0);
    check_equal("error_count_o", error_count, err_total);

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: sd_host_model.sv
// sd/spi host model
`timescale 1ns/10ps
`default_nettype none

`include "autotest_config.svh"

module sd_host_model
  import autotest_pkg::*;
#(
  parameter int MEM_BYTES = 16 * `AT_BLOCK_BYTES
) (
  input  wire         clk,
  input  wire         rst,
  input  spi_req_t    req_i,
  input  wire  [31:0] block_addr_i,
  output logic        busy_o,
  output logic [7:0]  data_o
);

  // card image, filled by the testbench
  logic [7:0] mem [0:MEM_BYTES-1];

  initial begin
    busy_o = 1'b0;
    data_o = 8'h00;
  end

  // requests sampled and answered on the falling edge
  always @(negedge clk) begin : host
    int   busy_left;
    int   ptr;
    logic open_q;
    if (rst) begin
      busy_left = 0;
      ptr       = 0;
      open_q    = 1'b0;
      busy_o    <= 1'b0;
      data_o    <= 8'h00;
    end else if (busy_left > 0) begin
      busy_left = busy_left - 1;
      if (busy_left == 0) begin
        busy_o <= 1'b0;
      end
    end else if (req_i.rst) begin
      open_q    = 1'b0;
      busy_left = 4;
      busy_o    <= 1'b1;
    end else if ((req_i.r_block || req_i.r_multi) && !open_q) begin
      // open a read, multi-block just runs on through memory
      open_q    = 1'b1;
      ptr       = int'(block_addr_i) * `AT_BLOCK_BYTES;
      busy_left = 3;
      busy_o    <= 1'b1;
    end else if (open_q && req_i.r_byte) begin
      data_o    <= mem[ptr % MEM_BYTES];
      ptr       = ptr + 1;
      busy_left = 2;
      busy_o    <= 1'b1;
    end else if (!req_i.r_block && !req_i.r_multi) begin
      open_q = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: autotest_top.sv
// autotest top level
`timescale 1ns/10ps
`default_nettype none

module autotest_top
  import autotest_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         spi_busy_i,
  input  wire  [7:0]  spi_data_i,
  output spi_req_t    spi_req_o,
  output logic [31:0] spi_block_addr_o,
  input  wire         uut_busy_i,
  input  wire         uut_end_i,
  input  wire         uut_err_i,
  input  wire  [31:0] uut_result_i,
  output logic        uut_rst_o,
  output logic [63:0] uut_input_o,
  output logic [31:0] feed_data_o,
  output logic        feed_strobe_o,
  output logic        stop_feed_o,
  output logic [31:0] error_count_o
);

  ctrl_block_t ctrl;
  logic        cap_clear;
  logic        cap_strobe;
  logic        cap_done;
  logic        feed_clear;
  logic        feed_byte_strobe;
  logic        feed_taken;
  logic        word_ready;
  logic        feed_done;

  assign uut_input_o = ctrl.uut_input;

  autotest_fsm i_autotest_fsm (
    .clk                (clk),
    .rst                (rst),
    .spi_busy_i         (spi_busy_i),
    .spi_req_o          (spi_req_o),
    .spi_block_addr_o   (spi_block_addr_o),
    .cap_clear_o        (cap_clear),
    .cap_strobe_o       (cap_strobe),
    .cap_done_i         (cap_done),
    .ctrl_i             (ctrl),
    .feed_clear_o       (feed_clear),
    .feed_byte_strobe_o (feed_byte_strobe),
    .feed_taken_o       (feed_taken),
    .word_ready_i       (word_ready),
    .feed_done_i        (feed_done),
    .uut_busy_i         (uut_busy_i),
    .uut_end_i          (uut_end_i),
    .uut_err_i          (uut_err_i),
    .uut_result_i       (uut_result_i),
    .uut_rst_o          (uut_rst_o),
    .feed_strobe_o      (feed_strobe_o),
    .stop_feed_o        (stop_feed_o),
    .error_count_o      (error_count_o)
  );

  ctrl_block_capture i_ctrl_block_capture (
    .clk           (clk),
    .rst           (rst),
    .clear_i       (cap_clear),
    .byte_strobe_i (cap_strobe),
    .byte_i        (spi_data_i),
    .ctrl_o        (ctrl),
    .block_done_o  (cap_done)
  );

  feed_assembler i_feed_assembler (
    .clk           (clk),
    .rst           (rst),
    .clear_i       (feed_clear),
    .byte_strobe_i (feed_byte_strobe),
    .byte_i        (spi_data_i),
    .total_bytes_i (ctrl.total_bytes),
    .feed_taken_i  (feed_taken),
    .word_o        (feed_data_o),
    .word_ready_o  (word_ready),
    .feed_done_o   (feed_done)
  );

endmodule

`default_nettype wire

// File: autotest_fsm.sv
// self-test sequencer
`timescale 1ns/10ps
`default_nettype none

`include "autotest_config.svh"

module autotest_fsm
  import autotest_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  // sd/spi host
  input  wire         spi_busy_i,
  output spi_req_t    spi_req_o,
  output logic [31:0] spi_block_addr_o,
  // control block capture
  output logic        cap_clear_o,
  output logic        cap_strobe_o,
  input  wire         cap_done_i,
  input  ctrl_block_t ctrl_i,
  // feed assembler
  output logic        feed_clear_o,
  output logic        feed_byte_strobe_o,
  output logic        feed_taken_o,
  input  wire         word_ready_i,
  input  wire         feed_done_i,
  // uut
  input  wire         uut_busy_i,
  input  wire         uut_end_i,
  input  wire         uut_err_i,
  input  wire  [31:0] uut_result_i,
  output logic        uut_rst_o,
  output logic        feed_strobe_o,
  output logic        stop_feed_o,
  output logic [31:0] error_count_o
);

  at_state_e   state_q;
  at_state_e   state_d;
  logic [31:0] cur_block_q;
  logic [31:0] timer_q;
  logic [31:0] result_q;
  logic        uut_err_q;
  logic        test_over;
  logic        mismatch;

  assign test_over = uut_end_i || uut_err_i || (timer_q >= `AT_TIMEOUT_CYCLES);
  assign mismatch  = (result_q != ctrl_i.expected) || uut_err_q;

  ////////////////////////////////////////////////////////////
  // next state and request levels
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d            = state_q;
    spi_req_o          = '0;
    uut_rst_o          = 1'b0;
    cap_clear_o        = 1'b0;
    cap_strobe_o       = 1'b0;
    feed_clear_o       = 1'b0;
    feed_byte_strobe_o = 1'b0;
    feed_taken_o       = 1'b0;
    feed_strobe_o      = 1'b0;
    stop_feed_o        = 1'b0;
    case (state_q)
      ST_INIT: begin
        uut_rst_o = 1'b1;
        state_d   = ST_SPI_RST;
      end
      ST_SPI_RST: begin
        uut_rst_o     = 1'b1;
        spi_req_o.rst = 1'b1;
        if (spi_busy_i) state_d = ST_SPI_RST_WAIT;
      end
      ST_SPI_RST_WAIT: begin
        uut_rst_o = 1'b1;
        if (!spi_busy_i) state_d = ST_IDLE;
      end
      ST_IDLE: begin
        uut_rst_o   = 1'b1;
        cap_clear_o = 1'b1;
        if (!spi_busy_i) state_d = ST_CB_OPEN;
      end
      // one r_byte per control block byte
      ST_CB_OPEN: begin
        uut_rst_o         = 1'b1;
        spi_req_o.r_block = 1'b1;
        if (spi_busy_i) state_d = ST_CB_OPEN_WAIT;
      end
      ST_CB_OPEN_WAIT: begin
        uut_rst_o         = 1'b1;
        spi_req_o.r_block = 1'b1;
        if (!spi_busy_i) state_d = ST_CB_BYTE;
      end
      ST_CB_BYTE: begin
        uut_rst_o         = 1'b1;
        spi_req_o.r_block = 1'b1;
        if (cap_done_i) begin
          state_d = ST_CHECK_SIG;
        end else begin
          spi_req_o.r_byte = 1'b1;
          if (spi_busy_i) state_d = ST_CB_BYTE_WAIT;
        end
      end
      ST_CB_BYTE_WAIT: begin
        uut_rst_o         = 1'b1;
        spi_req_o.r_block = 1'b1;
        if (!spi_busy_i) state_d = ST_CB_TAKE;
      end
      ST_CB_TAKE: begin
        uut_rst_o         = 1'b1;
        spi_req_o.r_block = 1'b1;
        cap_strobe_o      = 1'b1;
        state_d           = ST_CB_BYTE;
      end
      ST_CHECK_SIG: begin
        uut_rst_o = 1'b1;
        if (!spi_busy_i) begin
          if (ctrl_i.signature == `AT_SIGNATURE) begin
            feed_clear_o = 1'b1;
            state_d      = ST_FEED_OPEN;
          end else begin
            state_d = ST_HALT;
          end
        end
      end
      // multi-block feed read from the block after the control block
      ST_FEED_OPEN: begin
        spi_req_o.r_multi = 1'b1;
        if (spi_busy_i) state_d = ST_FEED_OPEN_WAIT;
      end
      ST_FEED_OPEN_WAIT: begin
        spi_req_o.r_multi = 1'b1;
        if (!spi_busy_i) state_d = ST_FEED_BYTE;
      end
      ST_FEED_BYTE: begin
        spi_req_o.r_multi = 1'b1;
        if (word_ready_i) begin
          state_d = ST_FEED_WORD;
        end else if (feed_done_i) begin
          state_d = ST_STOP_FEED;
        end else begin
          spi_req_o.r_byte = 1'b1;
          if (spi_busy_i) state_d = ST_FEED_BYTE_WAIT;
        end
      end
      ST_FEED_BYTE_WAIT: begin
        spi_req_o.r_multi = 1'b1;
        if (!spi_busy_i) state_d = ST_FEED_TAKE;
      end
      ST_FEED_TAKE: begin
        spi_req_o.r_multi  = 1'b1;
        feed_byte_strobe_o = 1'b1;
        state_d            = ST_FEED_BYTE;
      end
      ST_FEED_WORD: begin
        spi_req_o.r_multi = 1'b1;
        if (!uut_busy_i) begin
          feed_strobe_o = 1'b1;
          feed_taken_o  = 1'b1;
          state_d       = ST_UUT_BUSY_HI;
        end
      end
      // uut must show a busy pulse per word
      ST_UUT_BUSY_HI: begin
        spi_req_o.r_multi = 1'b1;
        if (uut_busy_i) state_d = ST_UUT_BUSY_LO;
      end
      ST_UUT_BUSY_LO: begin
        spi_req_o.r_multi = 1'b1;
        if (!uut_busy_i) state_d = ST_FEED_BYTE;
      end
      ST_STOP_FEED: begin
        stop_feed_o = 1'b1;
        state_d     = ST_WAIT_END;
      end
      ST_WAIT_END: begin
        if (test_over) state_d = ST_COMPARE;
      end
      ST_COMPARE: begin
        state_d = ST_IDLE;
      end
      ST_HALT: begin
        uut_rst_o = 1'b1;
      end
      default: begin
        state_d = ST_HALT;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // addressing, timer, error count
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q          <= ST_INIT;
      cur_block_q      <= `AT_START_BLOCK;
      spi_block_addr_o <= `AT_START_BLOCK;
      timer_q          <= '0;
      error_count_o    <= '0;
    end else begin
      state_q <= state_d;
      case (state_q)
        ST_IDLE:      spi_block_addr_o <= cur_block_q;
        ST_CHECK_SIG: spi_block_addr_o <= cur_block_q + 32'd1;
        ST_STOP_FEED: timer_q <= '0;
        ST_WAIT_END:  timer_q <= timer_q + 32'd1;
        ST_COMPARE: begin
          cur_block_q <= ctrl_i.next_block;
          if (mismatch) error_count_o <= error_count_o + 32'd1;
        end
        default: ;
      endcase
    end
  end

  // result sampled when the wait ends
  always_ff @(posedge clk) begin
    if (state_q == ST_WAIT_END && test_over) begin
      result_q  <= uut_result_i;
      uut_err_q <= uut_err_i;
    end
  end

  // the assembler still holds a complete word at each strobe
  a_feed_uut_idle: assert property (@(posedge clk) disable iff (rst)
    feed_strobe_o |-> !uut_busy_i && word_ready_i);

  // r_byte only rides on an open block read
  a_one_request: assert property (@(posedge clk) disable iff (rst)
    $onehot0({spi_req_o.rst, spi_req_o.r_block, spi_req_o.r_multi}) &&
    (!spi_req_o.r_byte || spi_req_o.r_block || spi_req_o.r_multi));

endmodule

`default_nettype wire

// File: feed_assembler.sv
// feed word assembler
`timescale 1ns/10ps
`default_nettype none

`include "autotest_config.svh"

module feed_assembler
  import autotest_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         clear_i,
  input  wire         byte_strobe_i,
  input  wire  [7:0]  byte_i,
  input  wire  [31:0] total_bytes_i,
  input  wire         feed_taken_i,
  output logic [31:0] word_o,
  output logic        word_ready_o,
  output logic        feed_done_o
);

  localparam int CNT_W = $clog2(`AT_FEED_BYTES);

  logic [31:0] consumed_q;

  // big endian, first byte ends up on top
  always_ff @(posedge clk) begin
    if (byte_strobe_i) begin
      word_o <= {word_o[23:0], byte_i};
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      consumed_q   <= '0;
      word_ready_o <= 1'b0;
    end else begin
      if (byte_strobe_i) begin
        consumed_q <= consumed_q + 32'd1;
      end
      if (byte_strobe_i && consumed_q[CNT_W-1:0] == CNT_W'(`AT_FEED_BYTES - 1)) begin
        word_ready_o <= 1'b1;
      end else if (feed_taken_i) begin
        word_ready_o <= 1'b0;
      end
    end
  end

  assign feed_done_o = (consumed_q == total_bytes_i);

  a_total_aligned: assert property (@(posedge clk) disable iff (rst)
    clear_i |=> (total_bytes_i % `AT_FEED_BYTES) == 0);

endmodule

`default_nettype wire

// File: ctrl_block_capture.sv
// control block capture
`timescale 1ns/10ps
`default_nettype none

`include "autotest_config.svh"

module ctrl_block_capture
  import autotest_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         clear_i,
  input  wire         byte_strobe_i,
  input  wire  [7:0]  byte_i,
  output ctrl_block_t ctrl_o,
  output logic        block_done_o
);

  localparam int OFF_W     = $clog2(`AT_BLOCK_BYTES) + 1;
  localparam int IN_IDX_W  = $clog2(`AT_INPUT_BYTES);
  localparam int OUT_IDX_W = $clog2(`AT_OUTPUT_BYTES);
  // byte offsets of each field
  localparam int OFF_INPUT = 4;
  localparam int OFF_NEXT  = OFF_INPUT + `AT_INPUT_BYTES;
  localparam int OFF_TOTAL = OFF_NEXT + 4;
  localparam int OFF_EXP   = OFF_TOTAL + 4;
  localparam int OFF_END   = OFF_EXP + `AT_OUTPUT_BYTES;

  logic [OFF_W-1:0] offset_q;
  logic [OFF_W-1:0] rel_input;
  logic [OFF_W-1:0] rel_next;
  logic [OFF_W-1:0] rel_total;
  logic [OFF_W-1:0] rel_exp;

  assign rel_input = offset_q - OFF_W'(OFF_INPUT);
  assign rel_next  = offset_q - OFF_W'(OFF_NEXT);
  assign rel_total = offset_q - OFF_W'(OFF_TOTAL);
  assign rel_exp   = offset_q - OFF_W'(OFF_EXP);

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      offset_q     <= '0;
      block_done_o <= 1'b0;
    end else if (byte_strobe_i) begin
      offset_q     <= offset_q + 1'b1;
      block_done_o <= (offset_q == OFF_W'(`AT_BLOCK_BYTES - 1));
    end
  end

  // signature msb first, the rest lsb first, tail skipped
  always_ff @(posedge clk) begin
    if (byte_strobe_i) begin
      if (offset_q < OFF_W'(OFF_INPUT)) begin
        ctrl_o.signature[{~offset_q[1:0], 3'b000} +: 8] <= byte_i;
      end else if (offset_q < OFF_W'(OFF_NEXT)) begin
        ctrl_o.uut_input[{rel_input[IN_IDX_W-1:0], 3'b000} +: 8] <= byte_i;
      end else if (offset_q < OFF_W'(OFF_TOTAL)) begin
        ctrl_o.next_block[{rel_next[1:0], 3'b000} +: 8] <= byte_i;
      end else if (offset_q < OFF_W'(OFF_EXP)) begin
        ctrl_o.total_bytes[{rel_total[1:0], 3'b000} +: 8] <= byte_i;
      end else if (offset_q < OFF_W'(OFF_END)) begin
        ctrl_o.expected[{rel_exp[OUT_IDX_W-1:0], 3'b000} +: 8] <= byte_i;
      end
    end
  end

  a_no_strobe_after_done: assert property (@(posedge clk) disable iff (rst)
    byte_strobe_i |-> !block_done_o);

endmodule

`default_nettype wire

// File: autotest_pkg.sv
// autotest shared types
`default_nettype none

`include "autotest_config.svh"

package autotest_pkg;

  typedef enum logic [4:0] {
    ST_INIT,
    ST_SPI_RST,
    ST_SPI_RST_WAIT,
    ST_IDLE,
    ST_CB_OPEN,
    ST_CB_OPEN_WAIT,
    ST_CB_BYTE,
    ST_CB_BYTE_WAIT,
    ST_CB_TAKE,
    ST_CHECK_SIG,
    ST_FEED_OPEN,
    ST_FEED_OPEN_WAIT,
    ST_FEED_BYTE,
    ST_FEED_BYTE_WAIT,
    ST_FEED_TAKE,
    ST_FEED_WORD,
    ST_UUT_BUSY_HI,
    ST_UUT_BUSY_LO,
    ST_STOP_FEED,
    ST_WAIT_END,
    ST_COMPARE,
    ST_HALT
  } at_state_e;

  // fields of one control block
  typedef struct packed {
    logic [31:0]                    signature;
    logic [`AT_INPUT_BYTES*8-1:0]   uut_input;
    logic [31:0]                    next_block;
    logic [31:0]                    total_bytes;
    logic [`AT_OUTPUT_BYTES*8-1:0]  expected;
  } ctrl_block_t;

  // request levels towards the sd/spi host
  typedef struct packed {
    logic rst;
    logic r_block;
    logic r_multi;
    logic r_byte;
  } spi_req_t;

endpackage

`default_nettype wire

// File: autotest_config.svh
// autotest parameters
`ifndef AUTOTEST_CONFIG_SVH
`define AUTOTEST_CONFIG_SVH

////////////////////////////////////////////////////////////
// uut vector sizes in bytes
////////////////////////////////////////////////////////////
`define AT_INPUT_BYTES    8
`define AT_OUTPUT_BYTES   4
`define AT_FEED_BYTES     4

////////////////////////////////////////////////////////////
// sd card layout
////////////////////////////////////////////////////////////
`define AT_BLOCK_BYTES    512
`define AT_SIGNATURE      32'hAABBCCDD
// first control block on the card
`define AT_START_BLOCK    32'd4

// cycles allowed between stop_feed and uut end
`define AT_TIMEOUT_CYCLES 32'd5000

`endif
